// File: rtl/muldiv_pkg.sv
package muldiv_pkg;

    localparam int data_w = 32;                 // Word width of RV32.

    typedef logic [data_w-1:0] data_t;

    // Operations in RV32M funct3 encoding.
    typedef enum logic [2:0] {
        MUL    = 3'b000,                        // Low half, signed x signed.
        MULH   = 3'b001,                        // High half, signed x signed.
        MULHSU = 3'b010,                        // High half, signed rs1 x unsigned rs2.
        MULHU  = 3'b011,                        // High half, unsigned x unsigned.
        DIV    = 3'b100,                        // Signed quotient.
        DIVU   = 3'b101,                        // Unsigned quotient.
        REM    = 3'b110,                        // Signed remainder.
        REMU   = 3'b111                         // Unsigned remainder.
    } funct3_e;

    // Issue request from the register block.
    typedef struct packed {
        data_t   rs1;
        data_t   rs2;
        funct3_e op;
    } op_req_t;

    // Operand stage output.
    typedef struct packed {
        data_t   a_mag;                         // Magnitude of rs1.
        data_t   b_mag;                         // Magnitude of rs2.
        funct3_e op;
        data_t   rs1;                           // Raw rs1 for the special results.
        logic    neg_prod;                      // Product must be negated.
        logic    neg_quot;                      // Quotient must be negated.
        logic    neg_rem;                       // Remainder takes the dividend sign.
        logic    div0;                          // Divide by zero.
        logic    div_of;                        // Signed overflow, -2^31 / -1.
        logic    reuse;                         // Same magnitudes as the last divider run.
    } opnd_t;

    // Execute stage output, unsigned results plus what the fixups need.
    typedef struct packed {
        logic [2*data_w-1:0] prod;
        data_t               quot;
        data_t               rem;
        funct3_e             op;
        data_t               rs1;
        logic                neg_prod;
        logic                neg_quot;
        logic                neg_rem;
        logic                div0;
        logic                div_of;
    } exec_t;

    // Status word read back at REG_OP.
    typedef struct packed {
        logic [data_w-3:0] rsvd;                // Reads as zero.
        logic              done;                // Result ready and not read yet.
        logic              busy;                // Operation in flight.
    } status_t;

endpackage

// File: rtl/wb_pkg.sv
package wb_pkg;

    // Classic cycle request, driven by the master.
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [1:0]  adr;                       // Word address.
        logic [31:0] dat;
    } wb_req_t;

    // Slave response.
    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    // *******************************************************************
    // Register map.
    // *******************************************************************
    localparam logic [1:0] REG_RS1    = 2'd0;  // First operand.
    localparam logic [1:0] REG_RS2    = 2'd1;  // Second operand.
    localparam logic [1:0] REG_OP     = 2'd2;  // Write funct3 to issue, read status.
    localparam logic [1:0] REG_RESULT = 2'd3;  // Result, read only.

endpackage

// File: rtl/restoring_divider.sv
module restoring_divider import muldiv_pkg::*; #(
    parameter int DIV_BITS = 1                  // Quotient bits per cycle, divides 32.
) (
    input  logic  clk,
    input  logic  rstLow,
    input  logic  start_i,
    input  data_t dividend_i,
    input  data_t divisor_i,
    output logic  done_o,
    output data_t quot_o,
    output data_t rem_o
);

    localparam int steps = data_w / DIV_BITS;   // Cycles per division.
    localparam int cnt_w = $clog2(steps + 1);

    logic [cnt_w-1:0] cnt_q;                    // Steps left, zero when idle.
    data_t            divisor_q;
    data_t            rem_q;                    // Partial remainder.
    data_t            quot_q;                   // Dividend shifts out, quotient shifts in.
    data_t            rem_nxt;
    data_t            quot_nxt;
    logic [data_w:0]  shifted;                  // Remainder with the next dividend bit.
    logic [data_w:0]  trial;                    // Trial subtraction, MSB is the borrow.

    // DIV_BITS trial subtractions chained in one cycle.
    always_comb begin
        rem_nxt  = rem_q;
        quot_nxt = quot_q;
        shifted  = '0;
        trial    = '0;
        for (int i = 0; i < DIV_BITS; i++) begin
            shifted  = {rem_nxt, quot_nxt[data_w-1]};
            trial    = shifted - {1'b0, divisor_q};
            rem_nxt  = trial[data_w] ? shifted[data_w-1:0] : trial[data_w-1:0];  // Restore.
            quot_nxt = {quot_nxt[data_w-2:0], ~trial[data_w]};
        end
    end

    always_ff @(posedge clk or negedge rstLow) begin
        if (!rstLow) begin
            cnt_q  <= '0;
            done_o <= 1'b0;
        end else begin
            done_o <= (cnt_q == cnt_w'(1));     // Pulse after the last step.
            if (start_i)           cnt_q <= cnt_w'(steps);
            else if (cnt_q != '0)  cnt_q <= cnt_q - 1'b1;
        end
    end

    // Results hold until the next start.
    always_ff @(posedge clk) begin
        if (start_i) begin
            divisor_q <= divisor_i;
            rem_q     <= '0;
            quot_q    <= dividend_i;
        end else if (cnt_q != '0) begin
            rem_q     <= rem_nxt;
            quot_q    <= quot_nxt;
        end
    end

    assign quot_o = quot_q;
    assign rem_o  = rem_q;

endmodule

// File: rtl/muldiv_wb_regs.sv
module muldiv_wb_regs import muldiv_pkg::*, wb_pkg::*; (
    input  logic    clk,
    input  logic    rstLow,
    input  wb_req_t wb_req_i,
    output wb_rsp_t wb_rsp_o,
    output logic    issue_o,
    output op_req_t req_o,
    input  logic    res_valid_i,
    input  data_t   res_i
);

    data_t   rs1_q;
    data_t   rs2_q;
    funct3_e op_q;
    data_t   result_q;                          // Last finished result.
    data_t   rdata_q;
    status_t status_q;
    logic    ack_q;
    logic    issue_q;
    logic    req;                               // New transfer seen this cycle.
    logic    stall;                             // Ack held back while busy.
    logic    accept;                            // Transfer acked at the next edge.
    logic    wr_op;                             // Accepted OP write, launches the request.
    logic    rd_res;                            // Accepted RESULT read.

    // ack_q masks the cycle where the master still holds stb after an ack.
    assign req    = wb_req_i.cyc & wb_req_i.stb & ~ack_q;
    assign stall  = req & status_q.busy &
                    ((wb_req_i.we & (wb_req_i.adr == REG_OP)) |
                     (~wb_req_i.we & (wb_req_i.adr == REG_RESULT)));
    assign accept = req & ~stall;
    assign wr_op  = accept & wb_req_i.we & (wb_req_i.adr == REG_OP);
    assign rd_res = accept & ~wb_req_i.we & (wb_req_i.adr == REG_RESULT);

    // *******************************************************************
    // Handshake and status.
    // *******************************************************************
    always_ff @(posedge clk or negedge rstLow) begin
        if (!rstLow) begin
            ack_q    <= 1'b0;
            issue_q  <= 1'b0;
            status_q <= '0;
        end else begin
            ack_q   <= accept;
            issue_q <= wr_op;                   // Issue rides on the acking cycle.
            if (wr_op) begin
                status_q.busy <= 1'b1;
                status_q.done <= 1'b0;
            end else if (res_valid_i) begin
                status_q.busy <= 1'b0;
                status_q.done <= 1'b1;
            end else if (rd_res) begin
                status_q.done <= 1'b0;          // Result consumed.
            end
        end
    end

    // Operand, opcode, result and read data.
    always_ff @(posedge clk) begin
        if (accept && wb_req_i.we) begin
            case (wb_req_i.adr)
                REG_RS1: rs1_q <= wb_req_i.dat;
                REG_RS2: rs2_q <= wb_req_i.dat;
                REG_OP:  op_q  <= funct3_e'(wb_req_i.dat[2:0]);
                default: ;                      // RESULT is read only.
            endcase
        end
        if (accept && !wb_req_i.we) begin
            case (wb_req_i.adr)
                REG_RS1: rdata_q <= rs1_q;
                REG_RS2: rdata_q <= rs2_q;
                REG_OP:  rdata_q <= status_q;
                default: rdata_q <= result_q;
            endcase
        end
        if (res_valid_i) result_q <= res_i;
    end

    assign wb_rsp_o.ack = ack_q;
    assign wb_rsp_o.dat = rdata_q;

    assign issue_o   = issue_q;
    assign req_o.rs1 = rs1_q;
    assign req_o.rs2 = rs2_q;
    assign req_o.op  = op_q;

endmodule

// File: rtl/muldiv_operand_stage.sv
module muldiv_operand_stage import muldiv_pkg::*; (
    input  logic    clk,
    input  logic    rstLow,
    input  logic    issue_i,
    input  op_req_t req_i,
    output logic    opnd_valid_o,
    output opnd_t   opnd_o
);

    logic  is_div;                              // DIV, DIVU, REM or REMU.
    logic  a_signed;
    logic  b_signed;
    logic  a_neg;
    logic  b_neg;
    data_t a_mag;
    data_t b_mag;
    logic  div0;
    logic  div_of;
    logic  reuse;
    logic  start_div;                           // This issue will run the divider.
    data_t prev_a_q;                            // Magnitudes of the last divider run.
    data_t prev_b_q;
    logic  prev_valid_q;

    assign is_div = req_i.op[2];

    // rs1 is signed except for MULHU, DIVU and REMU; rs2 also unsigned for MULHSU.
    assign a_signed = (req_i.op != MULHU) && (req_i.op != DIVU) && (req_i.op != REMU);
    assign b_signed = a_signed && (req_i.op != MULHSU);
    assign a_neg    = a_signed & req_i.rs1[data_w-1];
    assign b_neg    = b_signed & req_i.rs2[data_w-1];
    assign a_mag    = a_neg ? -req_i.rs1 : req_i.rs1;    // -2^31 stays 2^31 unsigned.
    assign b_mag    = b_neg ? -req_i.rs2 : req_i.rs2;

    // *******************************************************************
    // Special cases and remainder reuse.
    // *******************************************************************
    assign div0   = is_div & (req_i.rs2 == '0);
    assign div_of = is_div & b_signed & (req_i.rs1 == {1'b1, {(data_w-1){1'b0}}}) &
                    (&req_i.rs2);
    assign reuse  = is_div & ~div0 & ~div_of & prev_valid_q &
                    (a_mag == prev_a_q) & (b_mag == prev_b_q);
    assign start_div = issue_i & is_div & ~div0 & ~div_of & ~reuse;

    always_ff @(posedge clk or negedge rstLow) begin
        if (!rstLow) begin
            opnd_valid_o <= 1'b0;
            prev_a_q     <= '0;
            prev_b_q     <= '0;
            prev_valid_q <= 1'b0;               // No match before the first run.
        end else begin
            opnd_valid_o <= issue_i;
            if (start_div) begin
                prev_a_q     <= a_mag;
                prev_b_q     <= b_mag;
                prev_valid_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue_i) begin
            opnd_o.a_mag    <= a_mag;
            opnd_o.b_mag    <= b_mag;
            opnd_o.op       <= req_i.op;
            opnd_o.rs1      <= req_i.rs1;
            opnd_o.neg_prod <= ~is_div & (a_neg ^ b_neg);
            opnd_o.neg_quot <= is_div & (a_neg ^ b_neg);
            opnd_o.neg_rem  <= is_div & a_neg;  // Remainder follows the dividend.
            opnd_o.div0     <= div0;
            opnd_o.div_of   <= div_of;
            opnd_o.reuse    <= reuse;
        end
    end

endmodule

// File: rtl/muldiv_exec_stage.sv
module muldiv_exec_stage import muldiv_pkg::*; #(
    parameter int DIV_BITS = 1
) (
    input  logic  clk,
    input  logic  rstLow,
    input  logic  opnd_valid_i,
    input  opnd_t opnd_i,
    output logic  exec_valid_o,
    output exec_t exec_o
);

    logic  start_div;
    logic  fast_valid_q;                        // Multiply or special division, one cycle.
    logic  div_done;
    data_t div_quot;
    data_t div_rem;
    opnd_t hold_q;                              // Operands held while the divider runs.

    // Divider only for a plain division; others take the held quotient and remainder.
    assign start_div = opnd_valid_i & opnd_i.op[2] & ~opnd_i.div0 & ~opnd_i.div_of &
                       ~opnd_i.reuse;

    restoring_divider #(
        .DIV_BITS   (DIV_BITS)
    ) i_restoring_divider (
        .clk        (clk),
        .rstLow     (rstLow),
        .start_i    (start_div),
        .dividend_i (opnd_i.a_mag),
        .divisor_i  (opnd_i.b_mag),
        .done_o     (div_done),
        .quot_o     (div_quot),
        .rem_o      (div_rem)
    );

    always_ff @(posedge clk or negedge rstLow) begin
        if (!rstLow) fast_valid_q <= 1'b0;
        else         fast_valid_q <= opnd_valid_i & ~start_div;
    end

    always_ff @(posedge clk) begin
        if (opnd_valid_i) hold_q <= opnd_i;
    end

    assign exec_valid_o = fast_valid_q | div_done;

    // Single-cycle unsigned multiply of the held magnitudes.
    assign exec_o.prod     = hold_q.a_mag * hold_q.b_mag;
    assign exec_o.quot     = div_quot;
    assign exec_o.rem      = div_rem;
    assign exec_o.op       = hold_q.op;
    assign exec_o.rs1      = hold_q.rs1;
    assign exec_o.neg_prod = hold_q.neg_prod;
    assign exec_o.neg_quot = hold_q.neg_quot;
    assign exec_o.neg_rem  = hold_q.neg_rem;
    assign exec_o.div0     = hold_q.div0;
    assign exec_o.div_of   = hold_q.div_of;

endmodule

// File: rtl/muldiv_result_stage.sv
module muldiv_result_stage import muldiv_pkg::*; (
    input  logic  clk,
    input  logic  rstLow,
    input  logic  exec_valid_i,
    input  exec_t exec_i,
    output logic  res_valid_o,
    output data_t res_o
);

    logic [2*data_w-1:0] prod_s;                // Signed product.
    data_t               quot_s;
    data_t               rem_s;
    data_t               quot_f;                // After special cases.
    data_t               rem_f;
    data_t               res_d;

    // Sign fixups, two's complement of the magnitudes.
    assign prod_s = exec_i.neg_prod ? -exec_i.prod : exec_i.prod;
    assign quot_s = exec_i.neg_quot ? -exec_i.quot : exec_i.quot;
    assign rem_s  = exec_i.neg_rem  ? -exec_i.rem  : exec_i.rem;

    // ISA results for divide by zero and signed overflow.
    always_comb begin
        quot_f = quot_s;
        rem_f  = rem_s;
        if (exec_i.div0) begin
            quot_f = '1;                        // All ones.
            rem_f  = exec_i.rs1;
        end else if (exec_i.div_of) begin
            quot_f = exec_i.rs1;                // -2^31 back.
            rem_f  = '0;
        end
    end

    always_comb begin
        case (exec_i.op)
            MUL:                 res_d = prod_s[data_w-1:0];
            MULH, MULHSU, MULHU: res_d = prod_s[2*data_w-1:data_w];  // MULHU never negated.
            DIV, DIVU:           res_d = quot_f;
            default:             res_d = rem_f;
        endcase
    end

    always_ff @(posedge clk or negedge rstLow) begin
        if (!rstLow) res_valid_o <= 1'b0;
        else         res_valid_o <= exec_valid_i;
    end

    always_ff @(posedge clk) begin
        if (exec_valid_i) res_o <= res_d;
    end

endmodule

// File: rtl/muldiv_top.sv
module muldiv_top import muldiv_pkg::*, wb_pkg::*; #(
    parameter int DIV_BITS = 1
) (
    input  logic    clk,
    input  logic    rstLow,
    input  wb_req_t wb_req_i,
    output wb_rsp_t wb_rsp_o
);

    logic    issue;
    op_req_t req;
    logic    opnd_valid;
    opnd_t   opnd;
    logic    exec_valid;
    exec_t   exec;
    logic    res_valid;
    data_t   res;

    // *******************************************************************
    // Host port, then operand, execute and result stages.
    // *******************************************************************
    muldiv_wb_regs i_muldiv_wb_regs (
        .clk          (clk),
        .rstLow       (rstLow),
        .wb_req_i     (wb_req_i),
        .wb_rsp_o     (wb_rsp_o),
        .issue_o      (issue),
        .req_o        (req),
        .res_valid_i  (res_valid),
        .res_i        (res)
    );

    muldiv_operand_stage i_muldiv_operand_stage (
        .clk          (clk),
        .rstLow       (rstLow),
        .issue_i      (issue),
        .req_i        (req),
        .opnd_valid_o (opnd_valid),
        .opnd_o       (opnd)
    );

    muldiv_exec_stage #(
        .DIV_BITS     (DIV_BITS)
    ) i_muldiv_exec_stage (
        .clk          (clk),
        .rstLow       (rstLow),
        .opnd_valid_i (opnd_valid),
        .opnd_i       (opnd),
        .exec_valid_o (exec_valid),
        .exec_o       (exec)
    );

    muldiv_result_stage i_muldiv_result_stage (
        .clk          (clk),
        .rstLow       (rstLow),
        .exec_valid_i (exec_valid),
        .exec_i       (exec),
        .res_valid_o  (res_valid),
        .res_o        (res)
    );

endmodule

// File: include/muldiv_ref_model.svh
`ifndef MULDIV_REF_MODEL_SVH
`define MULDIV_REF_MODEL_SVH

// One step of a 32-bit Fibonacci LFSR, taps 32, 22, 2, 1.
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// *******************************************************************
// RV32M result of op on a and b, 64-bit arithmetic.
// *******************************************************************
function automatic logic [31:0] ref_muldiv(input logic [2:0] op,
                                           input logic [31:0] a,
                                           input logic [31:0] b);
    logic signed [63:0] sa;                     // Sign extended.
    logic signed [63:0] sb;
    logic signed [63:0] ua;                     // Zero extended.
    logic signed [63:0] ub;
    logic signed [63:0] r;
    sa = {{32{a[31]}}, a};
    sb = {{32{b[31]}}, b};
    ua = {32'b0, a};
    ub = {32'b0, b};
    case (op)
        3'b000: r = sa * sb;
        3'b001: r = (sa * sb) >>> 32;
        3'b010: r = (sa * ub) >>> 32;           // Signed by unsigned.
        3'b011: r = (ua * ub) >>> 32;
        3'b100: r = (b == '0) ? -64'sd1 : sa / sb;  // -2^31 / -1 wraps to rs1.
        3'b101: r = (b == '0) ? -64'sd1 : ua / ub;
        3'b110: r = (b == '0) ? ua : sa % sb;
        default: r = (b == '0) ? ua : ua % ub;
    endcase
    return r[31:0];
endfunction

`endif

// File: tests/muldiv_tb.sv
module muldiv_tb import muldiv_pkg::*, wb_pkg::*; ();

    `include "muldiv_ref_model.svh"

    localparam int div_bits      = 2;            // Divider speed under test.
    localparam int n_mul         = 300;
    localparam int n_div         = 300;
    localparam int n_directed    = 24;           // Reset, special, reuse and hold cases.
    localparam int wb_overhead   = 16;           // Cycles of bus traffic per operation.
    localparam int fast_wait_max = 3 + 2;        // Fixed latency plus the held read.
    localparam int watchdog_time = (n_mul + n_div + n_directed) * (40 + wb_overhead) * 8;

    logic        clk;
    logic        rstLow;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;
    logic [31:0] lfsr_q;                         // Random state.

    muldiv_top #(
        .DIV_BITS (div_bits)
    ) i_muldiv_top (
        .clk      (clk),
        .rstLow   (rstLow),
        .wb_req_i (wb_req),
        .wb_rsp_o (wb_rsp)
    );

    always #4 clk = ~clk;                        // Period of 8.

    // *******************************************************************
    // Failure reporting and compares.
    // *******************************************************************
    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1, "run stopped");
    endtask

    task automatic compare_result(input string name, input data_t exp, input data_t act);
        if (act !== exp)
            stop_with_failure($sformatf("FAIL time=%0t %s expected=%h actual=%h",
                                        $time, name, exp, act));
    endtask

    task automatic compare_status(input string name, input status_t exp, input status_t act);
        if (act !== exp)
            stop_with_failure($sformatf("FAIL time=%0t %s expected=%h actual=%h",
                                        $time, name, exp, act));
    endtask

    // Fast results must come within the fixed latency, full divisions after it.
    task automatic check_latency(input string what, input int cycles, input logic fast);
        if (fast && cycles > fast_wait_max)
            stop_with_failure($sformatf("%s took %0d cycles, the fixed latency allows %0d",
                                        what, cycles, fast_wait_max));
        if (!fast && cycles <= fast_wait_max)
            stop_with_failure($sformatf(
                "%s came back after %0d cycles, too soon for a divider run", what, cycles));
    endtask

    // *******************************************************************
    // Random numbers.
    // *******************************************************************
    function automatic data_t take_bits(input int n);
        data_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);          // One step per bit taken.
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    function automatic data_t pick_operand();
        logic [2:0] cls;
        cls = 3'(take_bits(3));
        case (cls)
            3'd0:    return '0;
            3'd1:    return '1;                  // Minus one when signed.
            3'd2:    return 32'h8000_0000;       // Most negative value.
            3'd3:    return take_bits(4);        // Small positive.
            3'd4:    return -take_bits(4);       // Small negative.
            default: return take_bits(32);
        endcase
    endfunction

    // *******************************************************************
    // Wishbone master driving on the falling edge.
    // *******************************************************************
    task automatic bus_transfer(input logic we, input logic [1:0] adr, input data_t wdat,
                                output data_t rdat, output int cycles);
        @(negedge clk);
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.dat = wdat;
        cycles = 0;
        do begin
            @(negedge clk);                      // Ack is stable here.
            cycles++;
        end while (!wb_rsp.ack);
        rdat   = wb_rsp.dat;
        wb_req = '0;
    endtask

    task automatic bus_write(input logic [1:0] adr, input data_t dat, output int cycles);
        data_t unused;
        bus_transfer(1'b1, adr, dat, unused, cycles);
    endtask

    task automatic bus_read(input logic [1:0] adr, output data_t dat, output int cycles);
        bus_transfer(1'b0, adr, '0, dat, cycles);
    endtask

    // Full operation with the result checked against the model.
    task automatic run_op(input funct3_e op, input data_t a, input data_t b,
                          output data_t res, output int cycles);
        int w;
        bus_write(REG_RS1, a, w);
        bus_write(REG_RS2, b, w);
        bus_write(REG_OP, {29'b0, op}, w);
        bus_read(REG_RESULT, res, cycles);
        compare_result($sformatf("RESULT %s %h %h", op.name(), a, b),
                       ref_muldiv(op, a, b), res);
    endtask

    // Watchdog scaled by the operation count.
    initial begin
        #(watchdog_time);
        stop_with_failure("timeout, the run did not finish in the allowed time");
    end

    initial begin
        data_t      a;
        data_t      b;
        data_t      res;
        int         cyc;
        status_t    exp_st;
        funct3_e    op;
        logic [1:0] sel;
        clk    = 1'b0;
        rstLow = 1'b0;
        wb_req = '0;
        lfsr_q = 32'h156a41f3;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rstLow = 1'b1;

        // Idle status and operand read back.
        bus_read(REG_OP, res, cyc);
        compare_status("status after reset", '0, status_t'(res));
        a = take_bits(32);
        b = take_bits(32);
        bus_write(REG_RS1, a, cyc);
        bus_write(REG_RS2, b, cyc);
        bus_read(REG_RS1, res, cyc);
        compare_result("RS1", a, res);
        bus_read(REG_RS2, res, cyc);
        compare_result("RS2", b, res);

        for (int i = 0; i < n_mul; i++) begin    // Multiplies.
            sel = 2'(take_bits(2));
            op  = funct3_e'({1'b0, sel});
            run_op(op, pick_operand(), pick_operand(), res, cyc);
        end
        for (int i = 0; i < n_div; i++) begin    // Divisions and remainders.
            sel = 2'(take_bits(2));
            op  = funct3_e'({1'b1, sel});
            run_op(op, pick_operand(), pick_operand(), res, cyc);
        end

        // *******************************************************************
        // Divide by zero and signed overflow at the fixed latency.
        // *******************************************************************
        a = take_bits(32);
        run_op(DIV, a, '0, res, cyc);
        compare_result("DIV by zero", '1, res);
        check_latency("DIV by zero", cyc, 1'b1);
        run_op(REM, a, '0, res, cyc);
        compare_result("REM by zero", a, res);
        check_latency("REM by zero", cyc, 1'b1);
        run_op(DIVU, a, '0, res, cyc);
        compare_result("DIVU by zero", '1, res);
        run_op(REMU, a, '0, res, cyc);
        compare_result("REMU by zero", a, res);
        run_op(DIV, 32'h8000_0000, '1, res, cyc);
        compare_result("DIV overflow", 32'h8000_0000, res);
        check_latency("DIV overflow", cyc, 1'b1);
        run_op(REM, 32'h8000_0000, '1, res, cyc);
        compare_result("REM overflow", '0, res);
        check_latency("REM overflow", cyc, 1'b1);

        // Quotient then remainder on equal magnitudes reuses the divider.
        a = take_bits(32) | 32'h8000_0000;       // Negative dividend.
        b = -(take_bits(16) | 32'd1);            // Negative divisor that is never zero.
        run_op(DIV, a, b, res, cyc);
        check_latency("DIV", cyc, 1'b0);
        run_op(REM, a, b, res, cyc);
        check_latency("REM after DIV", cyc, 1'b1);
        a = take_bits(32);
        b = take_bits(20) | 32'd1;
        run_op(DIVU, a, b, res, cyc);
        check_latency("DIVU", cyc, 1'b0);
        run_op(REMU, a, b, res, cyc);
        check_latency("REMU after DIVU", cyc, 1'b1);
        run_op(REMU, a ^ 32'd1, b, res, cyc);    // Changed dividend.
        check_latency("REMU on a new dividend", cyc, 1'b0);

        // OP write during a division is held until the unit is idle.
        bus_write(REG_RS1, take_bits(32), cyc);
        bus_write(REG_RS2, take_bits(8) | 32'd1, cyc);
        bus_write(REG_OP, {29'b0, DIVU}, cyc);
        bus_read(REG_OP, res, cyc);
        exp_st      = '0;
        exp_st.busy = 1'b1;
        compare_status("status during division", exp_st, status_t'(res));
        a = pick_operand();
        b = pick_operand();
        bus_write(REG_RS1, a, cyc);
        bus_write(REG_RS2, b, cyc);
        bus_write(REG_OP, {29'b0, MULH}, cyc);
        if (cyc <= 1)
            stop_with_failure("OP write was acked at once while a division was busy");
        bus_read(REG_RESULT, res, cyc);
        compare_result("RESULT after held issue", ref_muldiv(MULH, a, b), res);
        bus_read(REG_OP, res, cyc);
        compare_status("status after result read", '0, status_t'(res));

        $display("test passed");
        $finish;
    end

endmodule

// File: tb.f
+incdir+include
rtl/muldiv_pkg.sv
rtl/wb_pkg.sv
rtl/restoring_divider.sv
rtl/muldiv_wb_regs.sv
rtl/muldiv_operand_stage.sv
rtl/muldiv_exec_stage.sv
rtl/muldiv_result_stage.sv
rtl/muldiv_top.sv
tests/muldiv_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal -f tb.f --top-module muldiv_tb -o muldiv_tb
out=$(./obj_dir/muldiv_tb) || true
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qx "test passed"; then
    exit 0
fi
exit 1
